// File: common/gameCfgPkg.sv
// ******************************
// Word length is fixed at five letters.
// Counter widths cover at most 7 mistakes.
// ******************************
package gameCfgPkg;

    // Bits per letter code.
    localparam int letterWidth = 8;

    // Letters in one secret word.
    localparam int wordLength = 5;

    // Mistake counter width and upper bound of the mistake limit.
    localparam int mistakeWidth = 3;

    // Wide enough to count up to wordLength.
    localparam int countWidth = 3;

    // Flat width of a whole word.
    localparam int wordWidth = letterWidth * wordLength;

    // One bit per possible letter code.
    localparam int letterCodes = 1 << letterWidth;

endpackage

// File: common/gameTypesPkg.sv
// ******************************
// Letter 4 of the word is the first letter loaded.
// Phase encoding is 2 bits wide.
// ******************************
package gameTypesPkg;

    // Secret word read two ways.
    // The loader shifts the flat view while the matcher reads the letters.
    typedef union packed {
        logic [gameCfgPkg::wordWidth-1:0] flat;
        logic [gameCfgPkg::wordLength-1:0][gameCfgPkg::letterWidth-1:0] letters;
    } secretWord;

    // Controller phase.
    typedef enum logic [1:0] {
        idle    = 2'd0, // Word loading.
        playing = 2'd1,
        won     = 2'd2,
        lost    = 2'd3
    } gamePhase;

endpackage

// File: verilog/wordLoader.sv
// ******************************
// Letters shift in at the low end only while loadEn is high.
// The word is kept until overwritten. Only the count is cleared.
// ******************************
module wordLoader (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic                                loadEn,
    input  logic                                letterValid,
    input  logic [gameCfgPkg::letterWidth-1:0]  letterIn,
    input  logic                                clear,
    output gameTypesPkg::secretWord             word,
    output logic                                wordFull
);
    localparam int countWidth = gameCfgPkg::countWidth;
    localparam int letterWidth = gameCfgPkg::letterWidth;
    localparam int wordWidth = gameCfgPkg::wordWidth;
    localparam logic [countWidth-1:0] fullCount = countWidth'(gameCfgPkg::wordLength);

    logic [countWidth-1:0] letterCount;
    logic                  shiftEn;

    assign shiftEn = loadEn && letterValid;
    assign wordFull = (letterCount == fullCount);

    // Word shift. Oldest letter ends up in the top slot.
    always_ff @(posedge clk) begin
        if (shiftEn) begin
            word.flat <= {word.flat[wordWidth-letterWidth-1:0], letterIn};
        end
    end

    // Loaded letter count, saturating at five.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            letterCount <= '0;
        end else if (clear) begin
            letterCount <= '0;
        end else if (shiftEn && !wordFull) begin
            letterCount <= letterCount + 1'b1;
        end
    end

    countInRange: assert property (
        @(posedge clk) disable iff (!nRst)
        letterCount <= fullCount
    ) else $error("wordLoader letter count above word length");

endmodule

// File: verilog/letterMatcher.sv
// ******************************
// One cycle latency from guessTake to matchValid.
// A letter repeated in the word lights several mask bits.
// ******************************
module letterMatcher (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic                                guessTake,
    input  logic [gameCfgPkg::letterWidth-1:0]  guess,
    input  gameTypesPkg::secretWord             word,
    output logic [gameCfgPkg::wordLength-1:0]   hitMask,
    output logic                                matchValid,
    output logic [gameCfgPkg::letterWidth-1:0]  matchLetter
);
    localparam int wordLength = gameCfgPkg::wordLength;

    logic [wordLength-1:0] hitNext;

    // All five compares in parallel.
    always_comb begin
        for (int i = 0; i < wordLength; i++) begin
            hitNext[i] = (word.letters[i] == guess);
        end
    end

    // Result payload, qualified by matchValid.
    always_ff @(posedge clk) begin
        if (guessTake) begin
            hitMask     <= hitNext;
            matchLetter <= guess;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            matchValid <= 1'b0;
        end else begin
            matchValid <= guessTake; // One-cycle strobe per taken guess.
        end
    end

    // Each taken guess gives a result next cycle, against an unchanged word.
    validFollowsTake: assert property (
        @(posedge clk) disable iff (!nRst)
        guessTake |=> matchValid && $stable(word)
    ) else $error("letterMatcher result missing or word changed under a guess");

endmodule

// File: verilog/guessHistory.sv
// ******************************
// Test and set happen on the same edge.
// A letter on two consecutive cycles is a repeat the second time.
// ******************************
module guessHistory (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic                                guessTake,
    input  logic [gameCfgPkg::letterWidth-1:0]  guess,
    input  logic                                clear,
    output logic                                repeatFlag
);
    localparam int letterCodes = gameCfgPkg::letterCodes;

    logic [letterCodes-1:0] seenSet; // One bit per letter code.
    logic                   seenBefore;

    assign seenBefore = seenSet[guess];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            seenSet <= '0;
        end else if (clear) begin
            seenSet <= '0;
        end else if (guessTake) begin
            seenSet[guess] <= 1'b1;
        end
    end

    // Repeat result lines up with the matcher output.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            repeatFlag <= 1'b0;
        end else begin
            repeatFlag <= guessTake && seenBefore && !clear;
        end
    end

    repeatNeedsGuess: assert property (
        @(posedge clk) disable iff (!nRst)
        repeatFlag |-> $past(guessTake)
    ) else $error("guessHistory repeat flag without a taken guess");

endmodule

// File: game/gameController.sv
// ******************************
// Results arriving outside playing are dropped.
// maxMistakes must lie between 1 and 7.
// ******************************
module gameController #(
    parameter int maxMistakes = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  logic                                 confirm,
    input  logic                                 wordFull,
    input  logic                                 matchValid,
    input  logic [gameCfgPkg::wordLength-1:0]    hitMask,
    input  logic [gameCfgPkg::letterWidth-1:0]   matchLetter,
    input  logic                                 repeatFlag,
    output logic                                 gameRdy,
    output logic                                 loadEn,
    output logic                                 newGame,
    output logic [gameCfgPkg::letterWidth-1:0]   letter,
    output logic [gameCfgPkg::wordLength-1:0]    revealed,
    output logic [gameCfgPkg::countWidth-1:0]    correct,
    output logic [gameCfgPkg::mistakeWidth-1:0]  numMistake,
    output logic                                 mistake,
    output logic                                 repeatGuess,
    output logic                                 green,
    output logic                                 red
);
    localparam int wordLength = gameCfgPkg::wordLength;
    localparam int countWidth = gameCfgPkg::countWidth;
    localparam int mistakeWidth = gameCfgPkg::mistakeWidth;
    localparam logic [mistakeWidth-1:0] mistakeLimit = mistakeWidth'(maxMistakes);

    gameTypesPkg::gamePhase phase;

    logic [wordLength-1:0]   revealedNext;
    logic [mistakeWidth-1:0] mistakeNext;

    function automatic logic [countWidth-1:0] countOnes(input logic [wordLength-1:0] mask);
        logic [countWidth-1:0] total;
        total = '0;
        for (int i = 0; i < wordLength; i++) begin
            total = total + countWidth'(mask[i]);
        end
        return total;
    endfunction

    // Phase decode.
    assign gameRdy = (phase == gameTypesPkg::playing);
    assign loadEn  = (phase == gameTypesPkg::idle);
    assign green   = (phase == gameTypesPkg::won);
    assign red     = (phase == gameTypesPkg::lost);

    // Clears loader count and history on the edge that starts play.
    assign newGame = loadEn && confirm && wordFull;

    assign revealedNext = revealed | hitMask;
    assign mistakeNext  = numMistake + 1'b1;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            phase       <= gameTypesPkg::idle;
            letter      <= '0;
            revealed    <= '0;
            correct     <= '0;
            numMistake  <= '0;
            mistake     <= 1'b0;
            repeatGuess <= 1'b0;
        end else begin
            mistake     <= 1'b0; // Pulses by default.
            repeatGuess <= 1'b0;
            case (phase)
                gameTypesPkg::idle: begin
                    if (newGame) begin
                        phase <= gameTypesPkg::playing;
                    end
                end
                gameTypesPkg::playing: begin
                    if (confirm) begin
                        // Abandon the game and go back to loading.
                        phase      <= gameTypesPkg::idle;
                        revealed   <= '0;
                        correct    <= '0;
                        numMistake <= '0;
                    end else if (matchValid) begin
                        letter <= matchLetter;
                        if (repeatFlag) begin
                            repeatGuess <= 1'b1; // Costs nothing.
                        end else if (|hitMask) begin
                            revealed <= revealedNext;
                            correct  <= countOnes(revealedNext);
                            if (&revealedNext) begin
                                phase <= gameTypesPkg::won;
                            end
                        end else begin
                            numMistake <= mistakeNext;
                            mistake    <= 1'b1;
                            if (mistakeNext == mistakeLimit) begin
                                phase <= gameTypesPkg::lost;
                            end
                        end
                    end
                end
                default: begin
                    // Won or lost. Hold until the host confirms again.
                    if (confirm) begin
                        phase      <= gameTypesPkg::idle;
                        revealed   <= '0;
                        correct    <= '0;
                        numMistake <= '0;
                    end
                end
            endcase
        end
    end

    mistakesBounded: assert property (
        @(posedge clk) disable iff (!nRst)
        numMistake <= mistakeLimit
    ) else $error("gameController mistake count above limit");

    // A win needs every position revealed.
    endStatesExclusive: assert property (
        @(posedge clk) disable iff (!nRst)
        !(green && red) && (!green || &revealed)
    ) else $error("gameController end state inconsistent with counts");

endmodule

// File: verilog/wordGame.sv
// ******************************
// Guesses offered while gameRdy is low are dropped.
// Guess results appear two cycles after the strobe.
// ******************************
module wordGame #(
    parameter int maxMistakes = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  logic [gameCfgPkg::letterWidth-1:0]   letterIn,
    input  logic                                 letterValid,
    input  logic                                 confirm,
    input  logic [gameCfgPkg::letterWidth-1:0]   guess,
    input  logic                                 guessValid,
    output logic                                 gameRdy,
    output logic [gameCfgPkg::letterWidth-1:0]   letter,
    output logic [gameCfgPkg::wordLength-1:0]    revealed,
    output logic [gameCfgPkg::countWidth-1:0]    correct,
    output logic [gameCfgPkg::mistakeWidth-1:0]  numMistake,
    output logic                                 mistake,
    output logic                                 repeatGuess,
    output logic                                 green,
    output logic                                 red
);
    gameTypesPkg::secretWord               word;
    logic                                  wordFull;
    logic                                  loadEn;
    logic                                  newGame;
    logic                                  guessTake;
    logic [gameCfgPkg::wordLength-1:0]     hitMask;
    logic                                  matchValid;
    logic [gameCfgPkg::letterWidth-1:0]    matchLetter;
    logic                                  repeatFlag;

    assign guessTake = guessValid && gameRdy; // Only gate at this level.

    wordLoader u_loader (
        .clk         (clk),
        .nRst        (nRst),
        .loadEn      (loadEn),
        .letterValid (letterValid),
        .letterIn    (letterIn),
        .clear       (newGame),
        .word        (word),
        .wordFull    (wordFull)
    );

    letterMatcher u_matcher (
        .clk         (clk),
        .nRst        (nRst),
        .guessTake   (guessTake),
        .guess       (guess),
        .word        (word),
        .hitMask     (hitMask),
        .matchValid  (matchValid),
        .matchLetter (matchLetter)
    );

    guessHistory u_history (
        .clk        (clk),
        .nRst       (nRst),
        .guessTake  (guessTake),
        .guess      (guess),
        .clear      (newGame),
        .repeatFlag (repeatFlag)
    );

    gameController #(
        .maxMistakes (maxMistakes)
    ) u_controller (
        .clk         (clk),
        .nRst        (nRst),
        .confirm     (confirm),
        .wordFull    (wordFull),
        .matchValid  (matchValid),
        .hitMask     (hitMask),
        .matchLetter (matchLetter),
        .repeatFlag  (repeatFlag),
        .gameRdy     (gameRdy),
        .loadEn      (loadEn),
        .newGame     (newGame),
        .letter      (letter),
        .revealed    (revealed),
        .correct     (correct),
        .numMistake  (numMistake),
        .mistake     (mistake),
        .repeatGuess (repeatGuess),
        .green       (green),
        .red         (red)
    );

endmodule

// File: testbench/wordGameTb.sv
// ******************************
// Runs the DUT with maxMistakes at its default of 6.
// Random misses are lowercase and table letters uppercase.
// ******************************
module wordGameTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int letterWidth = gameCfgPkg::letterWidth;
    localparam int wordLength = gameCfgPkg::wordLength;
    localparam int maxMistakes = 6;
    localparam int rdyTimeout = 20; // Cycles allowed for gameRdy to rise.
    localparam int drawLimit = 200;

    localparam int opIdle = 0;
    localparam int opLoad = 1;
    localparam int opConfirm = 2;
    localparam int opGuess = 3;
    localparam int opPair = 4; // Same letter on two consecutive cycles.
    localparam int opMiss = 5; // LFSR letter absent from the word.

    localparam int phIdle = 0;
    localparam int phPlaying = 1;
    localparam int phWon = 2;
    localparam int phLost = 3;

    logic                                       clk = 1'b0;
    logic                                       nRst;
    logic [letterWidth-1:0]                     letterIn;
    logic [letterWidth-1:0]                     guess;
    logic                                       letterValid, confirm, guessValid;
    logic                                       gameRdy, mistake, repeatGuess, green, red;
    logic [letterWidth-1:0]                     letter;
    logic [wordLength-1:0]                      revealed;
    logic [gameCfgPkg::countWidth-1:0]          correct;
    logic [gameCfgPkg::mistakeWidth-1:0]        numMistake;

    // Stimulus table, one entry per step.
    int                     stepOp[$];
    logic [letterWidth-1:0] stepValue[$];
    logic [wordLength-1:0]  stepRevealed[$];
    int                     stepCorrect[$];
    int                     stepMistakes[$];
    logic                   stepGreen[$];
    logic                   stepRed[$];

    // Reference model state.
    int                     modelPhase;
    int                     modelCount;
    int                     modelCorrect;
    int                     modelMistakes;
    logic [wordLength-1:0]  modelRevealed;
    logic [letterWidth-1:0] modelLetter;
    logic [letterWidth-1:0] modelWord [wordLength]; // Index matches the revealed bit.
    logic                   modelTried [256];

    int          errorCount = 0;
    int          stepsPassed = 0;
    int          stepsFailed = 0;
    logic [31:0] lfsr = 32'hf2e6907a;

    always #10 clk = ~clk; // 20 ns period.

    wordGame u_dut (
        .clk         (clk),
        .nRst        (nRst),
        .letterIn    (letterIn),
        .letterValid (letterValid),
        .confirm     (confirm),
        .guess       (guess),
        .guessValid  (guessValid),
        .gameRdy     (gameRdy),
        .letter      (letter),
        .revealed    (revealed),
        .correct     (correct),
        .numMistake  (numMistake),
        .mistake     (mistake),
        .repeatGuess (repeatGuess),
        .green       (green),
        .red         (red)
    );

    task automatic addStep(input int op, input logic [letterWidth-1:0] value,
                           input logic [wordLength-1:0] rev, input int cor, input int mis,
                           input logic g, input logic r);
        stepOp.push_back(op);
        stepValue.push_back(value);
        stepRevealed.push_back(rev);
        stepCorrect.push_back(cor);
        stepMistakes.push_back(mis);
        stepGreen.push_back(g);
        stepRed.push_back(r);
    endtask

    task automatic buildTable();
        addStep(opIdle,    8'h00, 5'b00000, 0, 0, 1'b0, 1'b0); // Reset values.
        addStep(opLoad,    "L",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "E",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "V",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "E",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opConfirm, 8'h00, 5'b00000, 0, 0, 1'b0, 1'b0); // Four letters only.
        addStep(opLoad,    "L",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opConfirm, 8'h00, 5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opGuess,   "V",   5'b00100, 1, 0, 1'b0, 1'b0);
        addStep(opGuess,   "L",   5'b10101, 3, 0, 1'b0, 1'b0); // Two positions.
        addStep(opMiss,    8'h00, 5'b10101, 3, 1, 1'b0, 1'b0);
        addStep(opGuess,   "V",   5'b10101, 3, 1, 1'b0, 1'b0);
        addStep(opPair,    "Q",   5'b10101, 3, 2, 1'b0, 1'b0);
        addStep(opGuess,   "E",   5'b11111, 5, 2, 1'b1, 1'b0);
        addStep(opGuess,   "Z",   5'b11111, 5, 2, 1'b1, 1'b0); // After the win.
        addStep(opConfirm, 8'h00, 5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "C",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "R",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "A",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "N",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opLoad,    "E",   5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opConfirm, 8'h00, 5'b00000, 0, 0, 1'b0, 1'b0);
        addStep(opGuess,   "E",   5'b00001, 1, 0, 1'b0, 1'b0); // Tried last game.
        for (int m = 1; m <= maxMistakes; m++) begin
            addStep(opMiss, 8'h00, 5'b00001, 1, m, 1'b0, m == maxMistakes);
        end
        addStep(opGuess,   "C",   5'b00001, 1, 6, 1'b0, 1'b1); // After the loss.
        addStep(opConfirm, 8'h00, 5'b00000, 0, 0, 1'b0, 1'b0);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = nextLfsr(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic pickMiss(output logic [letterWidth-1:0] pick, output logic found);
        logic [7:0] bits;
        logic [7:0] cand;
        logic       inWord;
        found = 1'b0;
        pick = '0;
        for (int n = 0; n < drawLimit && !found; n++) begin
            takeBits(5, bits);
            cand = 8'h61 + bits; // Lowercase a upward.
            inWord = 1'b0;
            for (int p = 0; p < wordLength; p++) begin
                inWord = inWord || (modelWord[p] == cand);
            end
            if (bits < 8'd26 && !inWord && !modelTried[cand]) begin
                pick = cand;
                found = 1'b1;
            end
        end
    endtask

    task automatic modelLoad(input logic [letterWidth-1:0] value);
        if (modelPhase == phIdle) begin
            for (int p = wordLength - 1; p > 0; p--) begin
                modelWord[p] = modelWord[p-1]; // First letter ends in slot 4.
            end
            modelWord[0] = value;
            if (modelCount < wordLength) begin
                modelCount++;
            end
        end
    endtask

    task automatic modelConfirm();
        if (modelPhase != phIdle) begin
            modelPhase = phIdle;
            modelRevealed = '0;
            modelCorrect = 0;
            modelMistakes = 0;
        end else if (modelCount == wordLength) begin
            modelPhase = phPlaying;
            modelCount = 0;
            for (int c = 0; c < 256; c++) begin
                modelTried[c] = 1'b0;
            end
        end
    endtask

    task automatic modelGuess(input logic [letterWidth-1:0] value,
                              output logic expMistake, output logic expRepeat);
        logic [wordLength-1:0] hits;
        expMistake = 1'b0;
        expRepeat = 1'b0;
        if (modelPhase == phPlaying) begin
            modelLetter = value;
            if (modelTried[value]) begin
                expRepeat = 1'b1;
            end else begin
                modelTried[value] = 1'b1;
                for (int p = 0; p < wordLength; p++) begin
                    hits[p] = (modelWord[p] == value);
                end
                if (hits != '0) begin
                    modelRevealed = modelRevealed | hits;
                    modelCorrect = 0;
                    for (int p = 0; p < wordLength; p++) begin
                        modelCorrect += int'(modelRevealed[p]);
                    end
                    if (&modelRevealed) begin
                        modelPhase = phWon;
                    end
                end else begin
                    modelMistakes++;
                    expMistake = 1'b1;
                    if (modelMistakes == maxMistakes) begin
                        modelPhase = phLost;
                    end
                end
            end
        end
    endtask

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkPulses(input logic expMistake, input logic expRepeat);
        checkValue("mistake", int'(mistake), int'(expMistake));
        checkValue("repeatGuess", int'(repeatGuess), int'(expRepeat));
    endtask

    task automatic checkState(input int i);
        checkValue("revealed", int'(revealed), int'(stepRevealed[i]));
        checkValue("correct", int'(correct), stepCorrect[i]);
        checkValue("numMistake", int'(numMistake), stepMistakes[i]);
        checkValue("green", int'(green), int'(stepGreen[i]));
        checkValue("red", int'(red), int'(stepRed[i]));
        checkValue("gameRdy", int'(gameRdy), int'(modelPhase == phPlaying));
        checkValue("letter", int'(letter), int'(modelLetter));
    endtask

    task automatic runStep(input int i, output logic stalled);
        logic [letterWidth-1:0] value;
        logic                   found;
        logic                   firstMistake, firstRepeat;
        logic                   expMistake, expRepeat;
        int                     waited;
        stalled = 1'b0;
        expMistake = 1'b0;
        expRepeat = 1'b0;
        value = stepValue[i];
        if (stepOp[i] == opMiss) begin
            pickMiss(value, found);
            if (!found) begin
                $display("step %0d: the LFSR gave no fresh miss letter", i);
                errorCount++;
            end
        end
        @(posedge clk);
        case (stepOp[i])
            opLoad: begin
                letterIn <= value;
                letterValid <= 1'b1;
            end
            opConfirm: confirm <= 1'b1;
            opGuess, opPair, opMiss: begin
                guess <= value;
                guessValid <= 1'b1;
            end
            default: ; // Idle drives nothing.
        endcase
        @(posedge clk);
        if (stepOp[i] == opPair) begin
            @(posedge clk); // Second strobe of the pair.
        end
        letterValid <= 1'b0;
        confirm <= 1'b0;
        guessValid <= 1'b0;
        case (stepOp[i])
            opLoad: begin
                modelLoad(value);
                @(negedge clk);
            end
            opConfirm: begin
                modelConfirm();
                @(negedge clk);
                waited = 0;
                while (modelPhase == phPlaying && !gameRdy && waited < rdyTimeout) begin
                    @(negedge clk);
                    waited++;
                end
                if (modelPhase == phPlaying && !gameRdy) begin
                    $display("step %0d: gameRdy stayed low after a confirm, timed out", i);
                    errorCount++;
                    stalled = 1'b1;
                end
            end
            opGuess, opMiss: begin
                modelGuess(value, expMistake, expRepeat);
                repeat (2) @(negedge clk); // Result lands two cycles after the strobe.
            end
            opPair: begin
                modelGuess(value, firstMistake, firstRepeat);
                modelGuess(value, expMistake, expRepeat);
                @(negedge clk);
                checkPulses(firstMistake, firstRepeat);
                @(negedge clk);
            end
            default: @(negedge clk);
        endcase
        checkPulses(expMistake, expRepeat);
        checkState(i);
    endtask

    initial begin
        int   stepErrors;
        logic stalled;
        nRst = 1'b0;
        letterIn = '0;
        letterValid = 1'b0;
        confirm = 1'b0;
        guess = '0;
        guessValid = 1'b0;
        stalled = 1'b0;
        modelPhase = phIdle;
        modelCount = 0;
        modelCorrect = 0;
        modelMistakes = 0;
        modelRevealed = '0;
        modelLetter = '0;
        for (int p = 0; p < wordLength; p++) begin
            modelWord[p] = '0;
        end
        for (int c = 0; c < 256; c++) begin
            modelTried[c] = 1'b0;
        end
        buildTable();
        repeat (5) @(posedge clk);
        nRst <= 1'b1;
        for (int i = 0; i < stepOp.size() && !stalled; i++) begin
            stepErrors = errorCount;
            runStep(i, stalled);
            if (errorCount == stepErrors) begin
                stepsPassed++;
                $display("step %0d op %0d passed", i, stepOp[i]);
            end else begin
                stepsFailed++;
                $display("step %0d op %0d failed", i, stepOp[i]);
            end
        end
        $display("%0d steps passed, %0d failed, %0d errors", stepsPassed, stepsFailed,
                 errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
common/gameCfgPkg.sv
common/gameTypesPkg.sv
verilog/wordLoader.sv
verilog/letterMatcher.sv
verilog/guessHistory.sv
game/gameController.sv
verilog/wordGame.sv
testbench/wordGameTb.sv

// File: run.sh
#!/bin/sh
# Builds the simulation with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module wordGameTb \
    -f src.f -o wordGameSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/wordGameSim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
